// ==== adc_config.f ====
adc_cfg_pkg.sv
host_reg_decoder.sv
cfg_port_arbiter.sv
adc_cfg_ram.sv
adc_init_sequencer.sv
adc_serial_shifter.sv
adc_config.sv
adc_cfg_tb_clock.sv
adc_config_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= adc_config_tb
FILELIST  ?= adc_config.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== adc_config_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_config_tb;
	import adc_cfg_pkg::*;

	logic                  CLK;
	logic                  reset;
	logic                  host_sel;
	logic                  host_we;
	cfg_word_u             host_data;
	logic                  dbg_we;
	slot_t                 dbg_wr_addr;
	logic [word_width-1:0] dbg_wr_data;
	logic                  dbg_rd_sel;
	slot_t                 dbg_rd_addr;
	logic [word_width-1:0] dbg_rd_data;
	logic                  init;
	adc_mask_t             mask;
	logic [adc_count-1:0]  cs;
	logic                  sclk;
	logic                  sdata;
	logic                  done;

	logic [31:0]           lcg_state;                 // Random generator state
	logic [word_width-1:0] exp_mem [0:slot_count-1];  // Expected RAM contents

	adc_cfg_tb_clock i_adc_cfg_tb_clock (
		.CLK   (CLK),
		.reset (reset)
	);

	adc_config i_adc_config (
		.CLK         (CLK),
		.reset       (reset),
		.host_sel    (host_sel),
		.host_we     (host_we),
		.host_data   (host_data),
		.dbg_we      (dbg_we),
		.dbg_wr_addr (dbg_wr_addr),
		.dbg_wr_data (dbg_wr_data),
		.dbg_rd_sel  (dbg_rd_sel),
		.dbg_rd_addr (dbg_rd_addr),
		.dbg_rd_data (dbg_rd_data),
		.init        (init),
		.mask        (mask),
		.cs          (cs),
		.sclk        (sclk),
		.sdata       (sdata),
		.done        (done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
		return lcg_state;
	endfunction

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		$display("Test FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h got %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Debug read, data valid one cycle after the address
	task automatic read_and_check(input int slot);
		@(posedge CLK);
		dbg_rd_sel  <= 1'b1;
		dbg_rd_addr <= slot_t'(slot);
		@(posedge CLK);
		@(negedge CLK);
		check_value($sformatf("dbg_rd_data slot %0d", slot), 32'(exp_mem[slot]),
			32'(dbg_rd_data));
	endtask

	task automatic debug_write(input int slot, input logic [word_width-1:0] w);
		@(posedge CLK);
		dbg_we      <= 1'b1;
		dbg_wr_addr <= slot_t'(slot);
		dbg_wr_data <= w;
		@(posedge CLK);
		dbg_we <= 1'b0;
		exp_mem[slot] = w;  // Any slot, no decode on this path
	endtask

	// One serial word, sampled at falling CLK where all outputs are settled
	task automatic capture_word(input adc_mask_t m, output logic [word_width-1:0] w);
		int   cycles;
		int   nbits;
		logic prev_sclk;
		cycles = 0;
		nbits  = 0;
		w      = '0;
		@(negedge CLK);
		while (cs == '0) begin  // Gap between words, longer during a stall
			check_value("sclk", 32'd1, 32'(sclk));  // Idles high while deselected
			cycles++;
			if (cycles > 1000)
				report_failure("chip select never rose for the next word");
			@(negedge CLK);
		end
		cycles    = 0;
		prev_sclk = sclk;
		while (nbits < word_width) begin
			check_value("cs", 32'(m), 32'(cs));
			if (sclk && !prev_sclk) begin  // Rising SCLK, the ADC samples here
				w     = {w[word_width-2:0], sdata};
				nbits = nbits + 1;
			end
			prev_sclk = sclk;
			cycles++;
			if (cycles > 100)
				report_failure("serial word did not finish within 100 cycles");
			@(negedge CLK);
		end
		// cs held one cycle past the last edge, gone now
		check_value("cs", 32'd0, 32'(cs));
		check_value("sclk", 32'd1, 32'(sclk));
	endtask

	task automatic start_run(input adc_mask_t m);
		@(posedge CLK);
		dbg_rd_sel <= 1'b0;  // Free the read port for the sequencer
		mask       <= m;
		init       <= 1'b1;
		@(posedge CLK);
		init <= 1'b0;
		@(negedge CLK);
		check_value("done", 32'd0, 32'(done));  // Cleared right after acceptance
	endtask

	task automatic collect_run(input adc_mask_t m);
		logic [word_width-1:0] w;
		int                    i;
		int                    cycles;
		for (i = 0; i <= last_slot; i++) begin
			capture_word(m, w);
			check_value($sformatf("sdata word of slot %0d", i), 32'(exp_mem[i]), 32'(w));
			check_value("done", 32'd0, 32'(done));  // Never ahead of the last word
		end
		cycles = 0;
		while (!done) begin
			cycles++;
			if (cycles > 20)
				report_failure("done did not rise after the last word");
			@(negedge CLK);
		end
	endtask

	// Debug reader grabs the port mid-run and reads slot 7 meanwhile
	task automatic hold_read_port(input int delay, input int length);
		repeat (delay) @(posedge CLK);
		dbg_rd_sel  <= 1'b1;
		dbg_rd_addr <= slot_t'(7);
		repeat (length) begin
			@(posedge CLK);
			@(negedge CLK);
			check_value("dbg_rd_data slot 7", 32'(exp_mem[7]), 32'(dbg_rd_data));
		end
		@(posedge CLK);
		dbg_rd_sel <= 1'b0;
	endtask

	function automatic adc_mask_t random_mask();
		logic [31:0] r;
		r = lcg_next();
		if (r[11:0] == 12'h000)
			return adc_mask_t'(12'h001);  // An empty mask would hide the word
		return adc_mask_t'(r[11:0]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_host_writes();
		logic [31:0]           r;
		logic [word_width-1:0] w;
		int                    i;
		@(posedge CLK);
		host_sel <= 1'b1;
		for (i = 0; i <= last_slot; i++) begin
			r = lcg_next();
			w = {reg_map[i], r[15:0]};
			@(posedge CLK);
			host_we       <= 1'b1;  // Back to back strobes
			host_data.raw <= w;
			exp_mem[i] = w;  // Map index is the slot
		end
		@(posedge CLK);
		host_we <= 1'b0;
		@(posedge CLK);
		host_sel <= 1'b0;  // Kept one extra cycle for the decoder register
		for (i = 0; i <= last_slot; i++)
			read_and_check(i);
	endtask

	task automatic test_unknown_address();
		logic [31:0]           r;
		logic [word_width-1:0] w;
		int                    i;
		r = lcg_next();
		w = {8'h99, r[15:0]};  // 99 is not a register of the map
		@(posedge CLK);
		host_sel      <= 1'b1;
		host_we       <= 1'b1;
		host_data.raw <= w;
		@(posedge CLK);
		host_we <= 1'b0;
		@(posedge CLK);
		host_sel <= 1'b0;
		exp_mem[default_slot] = w;
		read_and_check(default_slot);
		for (i = 0; i <= last_slot; i++)
			read_and_check(i);  // Mapped slots untouched
	endtask

	task automatic test_debug_writes();
		logic [31:0] r;
		int          s;
		for (s = last_slot + 1; s < default_slot; s++) begin
			r = lcg_next();
			debug_write(s, {3'b110, 5'(s), r[15:0]});  // Upper byte carries the slot
		end
		r = lcg_next();
		debug_write(5, r[word_width-1:0]);  // Replaces the host word of slot 5
		for (s = 0; s < slot_count; s++)
			read_and_check(s);
	endtask

	task automatic test_full_init();
		adc_mask_t m;
		m = random_mask();
		start_run(m);
		collect_run(m);
	endtask

	task automatic test_read_stall();
		adc_mask_t m;
		check_value("done", 32'd1, 32'(done));  // Still set from the last run
		m = random_mask();
		start_run(m);
		fork
			collect_run(m);
			hold_read_port(300, 120);
		join
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		host_sel    <= 1'b0;
		host_we     <= 1'b0;
		host_data   <= '0;
		dbg_we      <= 1'b0;
		dbg_wr_addr <= '0;
		dbg_wr_data <= '0;
		dbg_rd_sel  <= 1'b0;
		dbg_rd_addr <= '0;
		init        <= 1'b0;
		mask        <= '0;
		lcg_state = 32'hcc2d8019;
		cycles    = 0;
		@(posedge CLK);
		while (reset !== 1'b0) begin
			cycles++;
			if (cycles > 40)
				report_failure("reset was never released");
			@(posedge CLK);
		end
		test_host_writes();
		test_unknown_address();
		test_debug_writes();
		test_full_init();
		test_read_stall();
		$display("Test OK");
		$finish;
	end

	// Last resort if some process stops making progress
	initial begin
		repeat (100000) @(posedge CLK);
		report_failure("simulation ran past its cycle limit");
	end

endmodule

`default_nettype wire

// ==== adc_cfg_tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

// Testbench clock and reset source
module adc_cfg_tb_clock (
	output logic CLK,
	output logic reset
);

	// 10 ns period
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		reset = 1'b1;                // Held from time zero
		repeat (16) @(posedge CLK);  // 16 cycles of reset
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== adc_config.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// ADC bank configuration top level
////////////////////////////////////////////////////////////////////////////
module adc_config (
	input  wire                                   CLK,
	input  wire                                   reset,
	// Host write
	input  wire                                   host_sel,
	input  wire                                   host_we,
	input  adc_cfg_pkg::cfg_word_u                host_data,
	// Debug write
	input  wire                                   dbg_we,
	input  adc_cfg_pkg::slot_t                    dbg_wr_addr,
	input  wire [adc_cfg_pkg::word_width-1:0]     dbg_wr_data,
	// Debug read
	input  wire                                   dbg_rd_sel,
	input  adc_cfg_pkg::slot_t                    dbg_rd_addr,
	output logic [adc_cfg_pkg::word_width-1:0]    dbg_rd_data,
	// Sequencer control
	input  wire                                   init,
	input  adc_cfg_pkg::adc_mask_t                mask,
	// ADC side
	output logic [adc_cfg_pkg::adc_count-1:0]     cs,
	output logic                                  sclk,
	output logic                                  sdata,
	output logic                                  done
);
	import adc_cfg_pkg::*;

	logic                  hw_we;        // Host request after decode
	slot_t                 hw_slot;
	logic [word_width-1:0] hw_word;
	logic                  seq_rd_req;   // Sequencer read handshake
	slot_t                 seq_rd_slot;
	logic                  seq_rd_gnt;
	logic                  ram_we;       // Arbitrated RAM ports
	slot_t                 ram_wr_addr;
	logic [word_width-1:0] ram_wr_data;
	slot_t                 ram_rd_addr;
	logic                  shift_load;   // Sequencer to shifter
	logic [word_width-1:0] shift_word;
	logic                  shift_busy;

	host_reg_decoder i_host_reg_decoder (
		.CLK       (CLK),
		.reset     (reset),
		.host_sel  (host_sel),
		.host_we   (host_we),
		.host_data (host_data),
		.hw_we     (hw_we),
		.hw_slot   (hw_slot),
		.hw_word   (hw_word)
	);

	cfg_port_arbiter i_cfg_port_arbiter (
		.CLK         (CLK),
		.reset       (reset),
		.hw_we       (hw_we),
		.hw_slot     (hw_slot),
		.hw_word     (hw_word),
		.host_sel    (host_sel),
		.dbg_we      (dbg_we),
		.dbg_wr_addr (dbg_wr_addr),
		.dbg_wr_data (dbg_wr_data),
		.dbg_rd_sel  (dbg_rd_sel),
		.dbg_rd_addr (dbg_rd_addr),
		.seq_rd_req  (seq_rd_req),
		.seq_rd_slot (seq_rd_slot),
		.seq_rd_gnt  (seq_rd_gnt),
		.ram_we      (ram_we),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.ram_rd_addr (ram_rd_addr)
	);

	// Read data feeds the debug port and the sequencer alike
	adc_cfg_ram i_adc_cfg_ram (
		.CLK     (CLK),
		.we      (ram_we),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.rd_addr (ram_rd_addr),
		.rd_data (dbg_rd_data)
	);

	adc_init_sequencer i_adc_init_sequencer (
		.CLK         (CLK),
		.reset       (reset),
		.init        (init),
		.seq_rd_req  (seq_rd_req),
		.seq_rd_slot (seq_rd_slot),
		.seq_rd_gnt  (seq_rd_gnt),
		.rd_data     (dbg_rd_data),  // Valid the cycle after a grant
		.shift_load  (shift_load),
		.shift_word  (shift_word),
		.shift_busy  (shift_busy),
		.done        (done)
	);

	adc_serial_shifter i_adc_serial_shifter (
		.CLK        (CLK),
		.reset      (reset),
		.shift_load (shift_load),
		.shift_word (shift_word),
		.mask       (mask),
		.shift_busy (shift_busy),
		.cs         (cs),
		.sclk       (sclk),
		.sdata      (sdata)
	);

endmodule

`default_nettype wire

// ==== adc_serial_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Serial shifter
// Half-rate SCLK idling high, 24-bit shift register, masked chip selects
////////////////////////////////////////////////////////////////////////////
module adc_serial_shifter (
	input  wire                                   CLK,
	input  wire                                   reset,
	input  wire                                   shift_load,  // Start a word
	input  wire [adc_cfg_pkg::word_width-1:0]     shift_word,
	input  adc_cfg_pkg::adc_mask_t                mask,        // ADCs to address
	output logic                                  shift_busy,
	output logic [adc_cfg_pkg::adc_count-1:0]     cs,          // Active high selects
	output logic                                  sclk,
	output logic                                  sdata
);
	import adc_cfg_pkg::*;

	logic [$clog2(2*word_width)-1:0] bit_cnt;  // Half periods left
	logic                            scken;    // Clock enable
	logic                            dscken;   // Enable delayed one CLK
	logic                            shen;     // Shift on this falling edge
	logic [word_width-1:0]           shreg;

	assign sdata = shreg[word_width-1];  // MSB first

	// Shift on falling SCLK, except the first, so the MSB gets a full period
	assign shen = scken & sclk & (bit_cnt != ($bits(bit_cnt))'(2*word_width-1));

	// Stretch by one CLK so cs outlives the last rising edge
	assign cs         = {adc_count{scken | dscken}} & mask;
	assign shift_busy = shift_load | scken | dscken;  // From load until cs drops

	//////////////////////////////////////////////////////////////////////////
	// Bit counter and SCLK generator
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			bit_cnt <= '0;
			scken   <= 1'b0;
			dscken  <= 1'b0;
			sclk    <= 1'b1;  // Idles high
		end else begin
			dscken <= scken;
			if (shift_load) begin
				bit_cnt <= ($bits(bit_cnt))'(2*word_width-1);  // 48 toggles
				scken   <= 1'b1;
			end else if (scken) begin
				bit_cnt <= bit_cnt - 1'b1;
				scken   <= (bit_cnt != '0);
			end
			sclk <= scken ? ~sclk : 1'b1;  // Half of CLK while enabled
		end
	end

	// Data path
	always_ff @(posedge CLK) begin
		if (shift_load)
			shreg <= shift_word;
		else if (shen)
			shreg <= {shreg[word_width-2:0], 1'b0};  // Shift left
	end

endmodule

`default_nettype wire

// ==== adc_init_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Init sequencer
// Walks slots 0..last_slot, fetches each word through the arbiter and
// hands it to the serial shifter
////////////////////////////////////////////////////////////////////////////
module adc_init_sequencer (
	input  wire                                   CLK,
	input  wire                                   reset,
	input  wire                                   init,         // Start pulse
	output logic                                  seq_rd_req,   // Read request to arbiter
	output adc_cfg_pkg::slot_t                    seq_rd_slot,  // Slot being fetched
	input  wire                                   seq_rd_gnt,
	input  wire [adc_cfg_pkg::word_width-1:0]     rd_data,      // RAM output
	output logic                                  shift_load,   // One-cycle load pulse
	output logic [adc_cfg_pkg::word_width-1:0]    shift_word,
	input  wire                                   shift_busy,
	output logic                                  done          // Run finished
);
	import adc_cfg_pkg::*;

	logic [2:0] state;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state       <= seq_idle;
			seq_rd_req  <= 1'b0;
			seq_rd_slot <= '0;
			shift_load  <= 1'b0;
			done        <= 1'b0;
		end else begin
			shift_load <= 1'b0;  // Pulse by default low
			case (state)
				seq_idle: begin
					// init outside idle is simply dropped
					if (init) begin
						seq_rd_slot <= '0;
						seq_rd_req  <= 1'b1;
						done        <= 1'b0;  // New run clears the old done
						state       <= seq_request;
					end
				end
				seq_request: begin
					// Stalls here as long as the debug reader holds the port
					if (seq_rd_gnt) begin
						seq_rd_req <= 1'b0;
						state      <= seq_fetch;
					end
				end
				seq_fetch: begin
					shift_word <= rd_data;  // Registered RAM read is valid now
					state      <= seq_load;
				end
				seq_load: begin
					if (!shift_busy) begin
						shift_load <= 1'b1;
						state      <= seq_wait;
					end
				end
				seq_wait: begin
					// Busy covers the load cycle, so no false idle here
					if (!shift_busy) begin
						if (seq_rd_slot == slot_t'(last_slot)) begin
							done  <= 1'b1;  // Last word is out
							state <= seq_idle;
						end else begin
							seq_rd_slot <= seq_rd_slot + 1'b1;
							seq_rd_req  <= 1'b1;
							state       <= seq_request;
						end
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== adc_cfg_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Configuration memory
// 32 x 24 distributed RAM, one write port, registered read port
////////////////////////////////////////////////////////////////////////////
module adc_cfg_ram (
	input  wire                                   CLK,
	input  wire                                   we,       // Write strobe
	input  adc_cfg_pkg::slot_t                    wr_addr,
	input  wire [adc_cfg_pkg::word_width-1:0]     wr_data,
	input  adc_cfg_pkg::slot_t                    rd_addr,
	output logic [adc_cfg_pkg::word_width-1:0]    rd_data   // Valid one cycle after rd_addr
);
	import adc_cfg_pkg::*;

	logic [word_width-1:0] mem [0:slot_count-1];  // Contents filled by the host or debug side

	// Write port
	always_ff @(posedge CLK) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// Read port
	// Same-slot write and read in one cycle returns the old word
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== cfg_port_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Port arbiter for the config RAM
// One write port shared by host and debug, one read port shared by
// the debug reader and the init sequencer
////////////////////////////////////////////////////////////////////////////
module cfg_port_arbiter (
	input  wire                                   CLK,
	input  wire                                   reset,
	// Host write request from the decoder
	input  wire                                   hw_we,
	input  adc_cfg_pkg::slot_t                    hw_slot,
	input  wire [adc_cfg_pkg::word_width-1:0]     hw_word,
	input  wire                                   host_sel,     // Write source select
	// Debug writer
	input  wire                                   dbg_we,
	input  adc_cfg_pkg::slot_t                    dbg_wr_addr,
	input  wire [adc_cfg_pkg::word_width-1:0]     dbg_wr_data,
	// Debug reader
	input  wire                                   dbg_rd_sel,   // Debug owns read port
	input  adc_cfg_pkg::slot_t                    dbg_rd_addr,
	// Sequencer reader
	input  wire                                   seq_rd_req,
	input  adc_cfg_pkg::slot_t                    seq_rd_slot,
	output logic                                  seq_rd_gnt,
	// RAM side
	output logic                                  ram_we,
	output adc_cfg_pkg::slot_t                    ram_wr_addr,
	output logic [adc_cfg_pkg::word_width-1:0]    ram_wr_data,
	output adc_cfg_pkg::slot_t                    ram_rd_addr
);

	logic gnt_q;  // Grant given in the previous cycle

	//////////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		if (host_sel) begin
			ram_we      = hw_we;
			ram_wr_addr = hw_slot;
			ram_wr_data = hw_word;
		end else begin
			ram_we      = dbg_we;       // Debug writes go anywhere
			ram_wr_addr = dbg_wr_addr;
			ram_wr_data = dbg_wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////////

	// Debug select wins outright, the sequencer just waits
	// One grant per request, a request still high right after its grant is stale
	assign seq_rd_gnt  = seq_rd_req & ~dbg_rd_sel & ~gnt_q;
	assign ram_rd_addr = dbg_rd_sel ? dbg_rd_addr : seq_rd_slot;

	always_ff @(posedge CLK) begin
		if (reset)
			gnt_q <= 1'b0;
		else
			gnt_q <= seq_rd_gnt;  // Data for this grant lands next cycle
	end

endmodule

`default_nettype wire

// ==== host_reg_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Host write path
// Turns the register-address byte of a host word into its memory slot
////////////////////////////////////////////////////////////////////////////
module host_reg_decoder (
	input  wire                                   CLK,
	input  wire                                   reset,
	input  wire                                   host_sel,   // Host owns the write port
	input  wire                                   host_we,    // Write strobe
	input  adc_cfg_pkg::cfg_word_u                host_data,  // Address byte + data
	output logic                                  hw_we,      // Qualified write request
	output adc_cfg_pkg::slot_t                    hw_slot,    // Decoded slot
	output logic [adc_cfg_pkg::word_width-1:0]    hw_word     // Word as stored
);
	import adc_cfg_pkg::*;

	slot_t dec_slot;  // Combinational lookup result

	// Search the register map
	// An address outside the map falls through to the spare slot
	always_comb begin
		dec_slot = slot_t'(default_slot);
		for (int i = 0; i <= last_slot; i++) begin
			if (host_data.fields.reg_addr == reg_map[i])
				dec_slot = slot_t'(i);  // Map index doubles as slot
		end
	end

	// Strobe qualified by the select level
	always_ff @(posedge CLK) begin
		if (reset) begin
			hw_we <= 1'b0;
		end else begin
			hw_we <= host_we & host_sel;  // No stray writes from a deselected host
		end
	end

	// Slot and word ride along with the strobe
	always_ff @(posedge CLK) begin
		hw_slot <= dec_slot;
		hw_word <= host_data.raw;  // Stored whole, address byte included
	end

endmodule

`default_nettype wire

// ==== adc_cfg_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// ADC configuration constants, register map and word layout
////////////////////////////////////////////////////////////////////////////
package adc_cfg_pkg;

	// Memory and bank sizes
	localparam int word_width   = 24;  // Address byte plus 16 data bits
	localparam int slot_count   = 32;  // Distributed RAM depth
	localparam int last_slot    = 16;  // Highest slot sent on init
	localparam int default_slot = 31;  // Catch-all for unknown reg addresses
	localparam int adc_count    = 12;  // Chip selects on the bank

	typedef logic [$clog2(slot_count)-1:0] slot_t;  // Memory slot index
	typedef logic [adc_count-1:0]          adc_mask_t;  // One bit per ADC

	// A config word is stored and shifted as a whole,
	// but the host decoder looks at the address byte only
	typedef union packed {
		logic [word_width-1:0] raw;  // Whole word, MSB goes out first
		struct packed {
			logic [7:0]  reg_addr;  // ADC register address
			logic [15:0] reg_data;  // Value for that register
		} fields;
	} cfg_word_u;

	// Recognized ADC register addresses, index is the slot number
	localparam logic [7:0] reg_map [0:last_slot] = '{
		8'h00, 8'h01, 8'h0f, 8'h11, 8'h12, 8'h14,
		8'h24, 8'h25, 8'h26, 8'h27, 8'h2a, 8'h2b,
		8'h42, 8'h45, 8'h46, 8'he2, 8'he3
	};

	// Init sequencer state codes
	localparam logic [2:0] seq_idle    = 3'd0;  // Waiting for init
	localparam logic [2:0] seq_request = 3'd1;  // Read request pending
	localparam logic [2:0] seq_fetch   = 3'd2;  // RAM word valid this cycle
	localparam logic [2:0] seq_load    = 3'd3;  // Waiting for idle shifter
	localparam logic [2:0] seq_wait    = 3'd4;  // Word on the wire

endpackage

`default_nettype wire
